// File: bench/CoreTb.sv
`timescale 1ns/1ps

module CoreTb import CorePkg::*; ();

   localparam int OUT_ADDR_W = 16;
   localparam int TIMEOUT = 1000;

   logic clk;
   logic reset;
   logic inReq;
   logic [DATA_W-1:0] inInstr;
   logic inAck;
   logic outAck;
   logic outReq;
   logic [OUT_ADDR_W-1:0] outAddr;
   logic [DATA_W-1:0] outData;

   integer seed = 35504;
   // Model register file, r0 never written
   logic [DATA_W-1:0] model [32];
   // Program words, with the ack delay bound in force for each
   logic [DATA_W-1:0] prog [$];
   int progDelay [$];
   logic [OUT_ADDR_W-1:0] expAddr [$];
   logic [DATA_W-1:0] expData [$];
   int ackDelayMax;
   int curDelay;
   int storeSlot;

   functT rFns [8] = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnSlt, FnSll, FnSrl};
   // Eight entries so three random bits index it
   opcodeT iOps [8] = '{OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui, OpAddiu, OpSw};

   MiniMipsCore #(.OUT_ADDR_W(OUT_ADDR_W)) MiniMipsCore_i (
      .clk(clk), .reset(reset), .inReq(inReq), .inInstr(inInstr),
      .outAck(outAck), .inAck(inAck), .outReq(outReq),
      .outAddr(outAddr), .outData(outData)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stopWithFailure();
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped after the first error");
   endtask

   task automatic checkValue(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
         stopWithFailure();
      end
   endtask

   function automatic logic [DATA_W-1:0] encodeR(input functT fn, input logic [4:0] rd,
         input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
      return {OpSpecial, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [DATA_W-1:0] encodeI(input opcodeT op, input logic [4:0] rt,
         input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // ISA reference, one instruction in program order
   function automatic void refStep(input logic [DATA_W-1:0] instr);
      logic [5:0] op;
      logic [5:0] fn;
      logic [4:0] rs, rt, rd, sh, dst;
      logic [DATA_W-1:0] a, b, sext, zext, res, addr;
      logic wr;
      op = instr[31:26];
      fn = instr[5:0];
      rs = instr[25:21];
      rt = instr[20:16];
      rd = instr[15:11];
      sh = instr[10:6];
      a = model[rs];
      b = model[rt];
      sext = {{16{instr[15]}}, instr[15:0]};
      zext = {16'h0000, instr[15:0]};
      wr = 1'b1;
      dst = rt;
      res = '0;
      case (op)
         OpSpecial: begin
            dst = rd;
            case (fn)
               FnAddu: res = a + b;
               FnSubu: res = a - b;
               FnAnd:  res = a & b;
               FnOr:   res = a | b;
               FnXor:  res = a ^ b;
               FnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               FnSll:  res = b << sh;
               FnSrl:  res = b >> sh;
               default: wr = 1'b0;
            endcase
         end
         OpAddiu: res = a + sext;
         OpSlti:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
         OpAndi:  res = a & zext;
         OpOri:   res = a | zext;
         OpXori:  res = a ^ zext;
         OpLui:   res = {instr[15:0], 16'h0000};
         OpSw: begin
            wr = 1'b0;
            addr = a + sext;
            expAddr.push_back(addr[OUT_ADDR_W-1:0]);
            expData.push_back(b);
         end
         default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) model[dst] = res;
   endfunction

   task automatic emit(input logic [DATA_W-1:0] instr);
      prog.push_back(instr);
      progDelay.push_back(curDelay);
      refStep(instr);
   endtask

   // Store to a fresh offset from r0
   task automatic storeReg(input logic [4:0] r);
      emit(encodeI(OpSw, r, 5'd0, storeSlot[15:0]));
      storeSlot += 4;
   endtask

   task automatic aluStore(input logic [DATA_W-1:0] instr, input logic [4:0] dst);
      emit(instr);
      storeReg(dst);
   endtask

   task automatic loadConst(input logic [4:0] r, input logic [DATA_W-1:0] v);
      emit(encodeI(OpLui, r, 5'd0, v[31:16]));
      emit(encodeI(OpOri, r, r, v[15:0]));
   endtask

   task automatic emitRandom();
      logic [31:0] r1, r2;
      logic [4:0] rd, rs, rt;
      r1 = $random(seed);
      r2 = $random(seed);
      // Low registers only, so dependencies are frequent
      rd = {1'b0, r2[3:0]};
      rs = {1'b0, r2[7:4]};
      rt = {1'b0, r2[11:8]};
      case (r1[4:3])
         2'd0: emit(encodeR(rFns[r1[2:0]], rd, rs, rt, r1[9:5]));
         2'd1: emit(encodeI(iOps[r1[2:0]], rt, rs, r1[31:16]));
         2'd2: emit(encodeI(OpSw, rt, rs, r1[31:16]));
         default: begin
            if (r1[2:0] == 3'd0) emit({6'h23, r1[25:0]});
            else if (r1[2:0] == 3'd1) emit({OpSpecial, r1[25:6], 6'h08});
            else emit(encodeR(rFns[r1[7:5]], rd, rs, rt, r1[12:8]));
         end
      endcase
   endtask

   task automatic buildPrograms();
      logic [31:0] rnd;
      logic [4:0] rx;
      curDelay = 5;
      loadConst(5'd1, 32'h1234_5678);
      loadConst(5'd2, 32'h8765_4321);
      loadConst(5'd3, 32'hFFFF_0000);
      loadConst(5'd4, 32'h0F0F_F0F0);
      loadConst(5'd5, 32'h7FFF_FFFF);
      loadConst(5'd6, 32'h8000_0000);
      // R-type arithmetic and logic
      aluStore(encodeR(FnAddu, 5'd9, 5'd1, 5'd2, 5'd0), 5'd9);
      aluStore(encodeR(FnSubu, 5'd10, 5'd1, 5'd2, 5'd0), 5'd10);
      aluStore(encodeR(FnAnd, 5'd11, 5'd3, 5'd4, 5'd0), 5'd11);
      aluStore(encodeR(FnOr, 5'd12, 5'd3, 5'd4, 5'd0), 5'd12);
      aluStore(encodeR(FnXor, 5'd13, 5'd1, 5'd4, 5'd0), 5'd13);
      aluStore(encodeR(FnAddu, 5'd14, 5'd5, 5'd5, 5'd0), 5'd14);
      // Immediate extension and LUI placement
      aluStore(encodeI(OpAddiu, 5'd15, 5'd1, 16'hFFF0), 5'd15);
      aluStore(encodeI(OpAddiu, 5'd16, 5'd0, 16'h8000), 5'd16);
      aluStore(encodeI(OpSlti, 5'd17, 5'd16, 16'hFFFF), 5'd17);
      aluStore(encodeI(OpSlti, 5'd18, 5'd0, 16'h8001), 5'd18);
      aluStore(encodeI(OpAndi, 5'd19, 5'd3, 16'hFFFF), 5'd19);
      aluStore(encodeI(OpOri, 5'd20, 5'd0, 16'h8001), 5'd20);
      aluStore(encodeI(OpXori, 5'd21, 5'd6, 16'hFFFF), 5'd21);
      aluStore(encodeI(OpLui, 5'd22, 5'd1, 16'hABCD), 5'd22);
      // Two stores back up the writer, dependent chain piles up behind
      curDelay = 12;
      for (int i = 0; i < 2; i++) begin
         storeReg(5'd1);
         storeReg(5'd2);
         emit(encodeI(OpAddiu, 5'd7, 5'd0, 16'h0007));
         emit(encodeR(FnAddu, 5'd7, 5'd7, 5'd7, 5'd0));
         emit(encodeR(FnAddu, 5'd8, 5'd7, 5'd7, 5'd0));
         storeReg(5'd8);
         emit(encodeI(OpSw, 5'd7, 5'd8, 16'h0010));
         emit(encodeR(FnSubu, 5'd8, 5'd8, 5'd7, 5'd0));
         storeReg(5'd8);
      end
      // Shift and signed compare edges
      curDelay = 5;
      aluStore(encodeR(FnSll, 5'd23, 5'd0, 5'd2, 5'd0), 5'd23);
      aluStore(encodeR(FnSll, 5'd24, 5'd0, 5'd2, 5'd31), 5'd24);
      aluStore(encodeR(FnSrl, 5'd25, 5'd0, 5'd6, 5'd31), 5'd25);
      aluStore(encodeR(FnSrl, 5'd26, 5'd0, 5'd3, 5'd4), 5'd26);
      aluStore(encodeR(FnSlt, 5'd27, 5'd6, 5'd5, 5'd0), 5'd27);
      aluStore(encodeR(FnSlt, 5'd28, 5'd5, 5'd6, 5'd0), 5'd28);
      aluStore(encodeR(FnSlt, 5'd29, 5'd1, 5'd1, 5'd0), 5'd29);
      // Long ack delays with dense stores
      curDelay = 30;
      for (int i = 0; i < 24; i++) begin
         rnd = $random(seed);
         rx = {1'b0, rnd[3:0]};
         emit(encodeI(OpAddiu, rx, {1'b0, rnd[7:4]}, rnd[31:16]));
         // Packed stages put these in E and F while the ADDIU sits in M
         emit(encodeI(OpSw, rx, rx, rnd[15:0]));
         emit(encodeI(OpSw, rx, rx, rnd[23:8]));
      end
      // r0 writes and undefined encodings change nothing
      curDelay = 5;
      emit(encodeI(OpAddiu, 5'd0, 5'd0, 16'h1234));
      aluStore(encodeR(FnAddu, 5'd0, 5'd1, 5'd2, 5'd0), 5'd0);
      aluStore({6'h23, 5'd2, 5'd1, 16'h0004}, 5'd1);
      aluStore({OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, 6'h08}, 5'd3);
      aluStore({6'h3F, 5'd1, 5'd2, 16'hFFFF}, 5'd2);
      for (int i = 0; i < 200; i++) emitRandom();
      // Final register state
      for (int i = 0; i < 16; i++) storeReg(i[4:0]);
   endtask

   task automatic waitInAck(input logic level);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout: inAck did not go to %0d", level);
            stopWithFailure();
         end
      end while (inAck !== level);
   endtask

   // Four-phase send of every program word
   task automatic sendAll();
      while (prog.size() > 0) begin
         @(posedge clk);
         inReq <= 1'b1;
         inInstr <= prog.pop_front();
         ackDelayMax <= progDelay.pop_front();
         waitInAck(1'b1);
         @(posedge clk);
         inReq <= 1'b0;
         waitInAck(1'b0);
      end
   endtask

   // Output link responder, one cycle per pass
   initial begin : ackResponder
      int phase;
      int delayLeft;
      int held;
      logic reqNow;
      outAck = 1'b0;
      phase = 0;
      delayLeft = 0;
      held = 0;
      forever begin
         @(negedge clk);
         reqNow = outReq;
         @(posedge clk);
         case (phase)
            0: if (reqNow) begin
               delayLeft = $unsigned($random(seed)) % (ackDelayMax + 1);
               phase = 1;
            end
            1: if (delayLeft == 0) begin
               outAck <= 1'b1;
               held = 0;
               phase = 2;
            end else begin
               delayLeft--;
            end
            default: if (!reqNow) begin
               outAck <= 1'b0;
               phase = 0;
            end else begin
               held++;
               if (held > TIMEOUT) begin
                  $display("Timeout: outReq stayed high after outAck");
                  stopWithFailure();
               end
            end
         endcase
      end
   end

   // Each outReq rise must match the next expected store
   initial begin : compareStores
      logic reqPrev;
      logic [OUT_ADDR_W-1:0] ea;
      logic [DATA_W-1:0] ed;
      reqPrev = 1'b0;
      forever begin
         @(negedge clk);
         if (outReq && !reqPrev) begin
            if (expData.size() == 0) begin
               $display("A store came out when none was expected");
               stopWithFailure();
            end else begin
               ea = expAddr.pop_front();
               ed = expData.pop_front();
               checkValue("outAddr", DATA_W'(outAddr), DATA_W'(ea));
               checkValue("outData", outData, ed);
            end
         end
         reqPrev = outReq;
      end
   end

   initial begin : mainFlow
      int cycles;
      reset = 1'b1;
      inReq = 1'b0;
      inInstr = '0;
      ackDelayMax = 5;
      storeSlot = 0;
      for (int i = 0; i < 32; i++) model[i] = '0;
      buildPrograms();
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      sendAll();
      // Drain the remaining stores
      cycles = 0;
      while (expAddr.size() > 0 && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      // Room for a duplicate store to show up
      repeat (50) @(negedge clk);
      if (expAddr.size() != 0) begin
         $display("Timeout: %0d expected stores never came out", expAddr.size());
         stopWithFailure();
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: design/Alu.sv
`timescale 1ns/1ps

module Alu import CorePkg::*; (
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] b,
   input  aluOpT             aluOp,
   output logic [DATA_W-1:0] result
);

   logic [4:0] shiftAmt;

   // Shift amount comes from a, shifted value is b
   assign shiftAmt = a[4:0];

   always_comb begin
      case (aluOp)
         AluAdd: result = a + b;
         AluSub: result = a - b;
         AluAnd: result = a & b;
         AluOr:  result = a | b;
         AluXor: result = a ^ b;
         // Signed compare
         AluSlt: result = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
         AluSll: result = b << shiftAmt;
         AluSrl: result = b >> shiftAmt;
         // Immediate is already in the upper half
         AluLui: result = b;
         default: result = '0;
      endcase
   end

endmodule

// File: design/CorePkg.sv
package CorePkg;

   // Datapath and register index widths
   localparam int DATA_W = 32;
   localparam int REG_IDX_W = 5;

   // Primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      OpSpecial = 6'h00,
      OpAddiu   = 6'h09,
      OpSlti    = 6'h0A,
      OpAndi    = 6'h0C,
      OpOri     = 6'h0D,
      OpXori    = 6'h0E,
      OpLui     = 6'h0F,
      OpSw      = 6'h2B
   } opcodeT;

   // R-type function codes, bits 5:0
   typedef enum logic [5:0] {
      FnSll  = 6'h00,
      FnSrl  = 6'h02,
      FnAddu = 6'h21,
      FnSubu = 6'h23,
      FnAnd  = 6'h24,
      FnOr   = 6'h25,
      FnXor  = 6'h26,
      FnSlt  = 6'h2A
   } functT;

   // ALU operation select
   typedef enum logic [3:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluOr,
      AluXor,
      AluSlt,
      AluSll,
      AluSrl,
      AluLui
   } aluOpT;

   // Four-phase link states, shared by receive and send sides
   typedef enum logic [1:0] {
      LinkIdle,
      LinkHolding,
      LinkWaitRelease
   } linkStateT;

endpackage

// File: design/ExecPipe.sv
`timescale 1ns/1ps

module ExecPipe import CorePkg::*; #(
   parameter int OUT_ADDR_W = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  slotValid,
   input  logic [DATA_W-1:0]     slotInstr,
   input  logic                  writerReady,
   output logic                  issue,
   output logic                  storeFire,
   output logic [OUT_ADDR_W-1:0] storeAddr,
   output logic [DATA_W-1:0]     storeData
);

   logic stall;

   // F stage
   logic fValid;
   logic [DATA_W-1:0] fInstr;
   logic [REG_IDX_W-1:0] decRs, decRt, decDest;
   logic [4:0] decShamt;
   aluOpT decAluOp;
   logic decUseImm, decUseShamt, decRegWrite, decIsStore;
   logic [DATA_W-1:0] decImm, rfRd1, rfRd2, fRsVal, fRtVal;

   // E stage
   logic eValid, eUseImm, eUseShamt, eRegWrite, eIsStore;
   aluOpT eAluOp;
   logic [REG_IDX_W-1:0] eRs, eRt, eDest;
   logic [4:0] eShamt;
   logic [DATA_W-1:0] eImm, eRsVal, eRtVal, eRsFwd, eRtFwd;
   logic [DATA_W-1:0] aluA, aluB, aluResult;

   // M stage
   logic mValid, mRegWrite, mIsStore, mWrites;
   logic [REG_IDX_W-1:0] mDest;
   logic [DATA_W-1:0] mResult, mStoreData;

   // M result matches a source index, r0 excluded via mWrites
   function automatic logic fwdHit(input logic [REG_IDX_W-1:0] src);
      return mWrites && (mDest == src);
   endfunction

   // Store in M waiting on a busy writer freezes everything
   assign stall     = mValid && mIsStore && !writerReady;
   assign storeFire = mValid && mIsStore && writerReady;
   assign issue     = slotValid && !stall;
   assign mWrites   = mValid && mRegWrite && (mDest != '0);

   InstrDecoder decoder_i (
      .instr(fInstr), .rs(decRs), .rt(decRt), .shamt(decShamt),
      .aluOp(decAluOp), .useImm(decUseImm), .useShamt(decUseShamt),
      .signExt(), .regWrite(decRegWrite), .isStore(decIsStore),
      .dest(decDest), .imm(decImm)
   );

   // Write-back at the end of the M cycle
   RegFile regFile_i (
      .clk(clk), .reset(reset), .ra1(decRs), .ra2(decRt),
      .we(mWrites && !stall), .wa(mDest), .wd(mResult),
      .rd1(rfRd1), .rd2(rfRd2)
   );

   // M to F forwarding covers the same-cycle register write
   assign fRsVal = fwdHit(decRs) ? mResult : rfRd1;
   assign fRtVal = fwdHit(decRt) ? mResult : rfRd2;

   // M to E forwarding for the instruction right behind
   assign eRsFwd = fwdHit(eRs) ? mResult : eRsVal;
   assign eRtFwd = fwdHit(eRt) ? mResult : eRtVal;
   assign aluA = eUseShamt ? {{(DATA_W-5){1'b0}}, eShamt} : eRsFwd;
   assign aluB = eUseImm ? eImm : eRtFwd;

   Alu alu_i (.a(aluA), .b(aluB), .aluOp(eAluOp), .result(aluResult));

   // Store address is the low bits of rs plus offset
   assign storeAddr = mResult[OUT_ADDR_W-1:0];
   assign storeData = mStoreData;

   // Valid and control bits
   always_ff @(posedge clk) begin
      if (reset) begin
         fValid    <= 1'b0;
         eValid    <= 1'b0;
         eRegWrite <= 1'b0;
         eIsStore  <= 1'b0;
         mValid    <= 1'b0;
         mRegWrite <= 1'b0;
         mIsStore  <= 1'b0;
      end else if (!stall) begin
         // Bubble enters F when no slot is valid
         fValid    <= slotValid;
         eValid    <= fValid;
         eRegWrite <= decRegWrite;
         eIsStore  <= decIsStore;
         mValid    <= eValid;
         mRegWrite <= eRegWrite;
         mIsStore  <= eIsStore;
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (!stall) begin
         fInstr     <= slotInstr;
         eAluOp     <= decAluOp;
         eUseImm    <= decUseImm;
         eUseShamt  <= decUseShamt;
         eRs        <= decRs;
         eRt        <= decRt;
         eDest      <= decDest;
         eShamt     <= decShamt;
         eImm       <= decImm;
         eRsVal     <= fRsVal;
         eRtVal     <= fRtVal;
         mDest      <= eDest;
         mResult    <= aluResult;
         mStoreData <= eRtFwd;
      end
   end

endmodule

// File: design/InstrDecoder.sv
`timescale 1ns/1ps

module InstrDecoder import CorePkg::*; (
   input  logic [DATA_W-1:0]    instr,
   output logic [REG_IDX_W-1:0] rs,
   output logic [REG_IDX_W-1:0] rt,
   output logic [4:0]           shamt,
   output aluOpT                aluOp,
   output logic                 useImm,
   output logic                 useShamt,
   output logic                 signExt,
   output logic                 regWrite,
   output logic                 isStore,
   output logic [REG_IDX_W-1:0] dest,
   output logic [DATA_W-1:0]    imm
);

   opcodeT opcode;
   functT funct;
   logic [REG_IDX_W-1:0] rd;
   logic [15:0] imm16;

   // Field split
   assign opcode = opcodeT'(instr[31:26]);
   assign funct  = functT'(instr[5:0]);
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign shamt  = instr[10:6];
   assign imm16  = instr[15:0];

   // rd for R-type, rt otherwise
   assign dest = (opcode == OpSpecial) ? rd : rt;

   always_comb begin
      aluOp    = AluAdd;
      useImm   = 1'b0;
      useShamt = 1'b0;
      signExt  = 1'b0;
      regWrite = 1'b0;
      isStore  = 1'b0;
      case (opcode)
         OpSpecial: begin
            regWrite = 1'b1;
            case (funct)
               FnAddu: aluOp = AluAdd;
               FnSubu: aluOp = AluSub;
               FnAnd:  aluOp = AluAnd;
               FnOr:   aluOp = AluOr;
               FnXor:  aluOp = AluXor;
               FnSlt:  aluOp = AluSlt;
               FnSll: begin
                  aluOp    = AluSll;
                  useShamt = 1'b1;
               end
               FnSrl: begin
                  aluOp    = AluSrl;
                  useShamt = 1'b1;
               end
               // Unknown funct is a no-op
               default: regWrite = 1'b0;
            endcase
         end
         OpAddiu: {aluOp, useImm, signExt, regWrite} = {AluAdd, 3'b111};
         OpSlti:  {aluOp, useImm, signExt, regWrite} = {AluSlt, 3'b111};
         OpAndi:  {aluOp, useImm, regWrite} = {AluAnd, 2'b11};
         OpOri:   {aluOp, useImm, regWrite} = {AluOr, 2'b11};
         OpXori:  {aluOp, useImm, regWrite} = {AluXor, 2'b11};
         OpLui:   {aluOp, useImm, regWrite} = {AluLui, 2'b11};
         // Address is rs plus signed offset
         OpSw:    {aluOp, useImm, signExt, isStore} = {AluAdd, 3'b111};
         default: ;
      endcase
   end

   // Immediate extension, LUI goes to the upper half
   always_comb begin
      if (opcode == OpLui) imm = {imm16, {(DATA_W-16){1'b0}}};
      else if (signExt) imm = {{(DATA_W-16){imm16[15]}}, imm16};
      else imm = {{(DATA_W-16){1'b0}}, imm16};
   end

endmodule

// File: design/InstrIntake.sv
`timescale 1ns/1ps

module InstrIntake import CorePkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic              inReq,
   input  logic [DATA_W-1:0] inInstr,
   input  logic              issue,
   output logic              inAck,
   output logic              slotValid,
   output logic [DATA_W-1:0] slotInstr
);

   linkStateT state;

   // Ack is high while holding and for one cycle after req falls
   assign inAck = (state != LinkIdle);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= LinkIdle;
      end else begin
         case (state)
            // Capture only into an empty slot
            LinkIdle: if (inReq && !slotValid) state <= LinkHolding;
            LinkHolding: if (!inReq) state <= LinkWaitRelease;
            LinkWaitRelease: state <= LinkIdle;
            default: state <= LinkIdle;
         endcase
      end
   end

   // Slot fills on capture, empties on issue
   always_ff @(posedge clk) begin
      if (reset) begin
         slotValid <= 1'b0;
      end else if (state == LinkIdle && inReq && !slotValid) begin
         slotValid <= 1'b1;
      end else if (issue) begin
         slotValid <= 1'b0;
      end
   end

   // Held instruction word
   always_ff @(posedge clk) begin
      if (state == LinkIdle && inReq && !slotValid) slotInstr <= inInstr;
   end

endmodule

// File: design/MiniMipsCore.sv
`timescale 1ns/1ps

module MiniMipsCore import CorePkg::*; #(
   parameter int OUT_ADDR_W = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  inReq,
   input  logic [DATA_W-1:0]     inInstr,
   input  logic                  outAck,
   output logic                  inAck,
   output logic                  outReq,
   output logic [OUT_ADDR_W-1:0] outAddr,
   output logic [DATA_W-1:0]     outData
);

   // Intake to pipeline
   logic slotValid;
   logic [DATA_W-1:0] slotInstr;
   logic issue;

   // Pipeline to writer
   logic writerReady;
   logic storeFire;
   logic [OUT_ADDR_W-1:0] storeAddr;
   logic [DATA_W-1:0] storeData;

   InstrIntake intake_i (
      .clk(clk), .reset(reset), .inReq(inReq), .inInstr(inInstr),
      .issue(issue), .inAck(inAck), .slotValid(slotValid),
      .slotInstr(slotInstr)
   );

   ExecPipe #(.OUT_ADDR_W(OUT_ADDR_W)) pipe_i (
      .clk(clk), .reset(reset), .slotValid(slotValid), .slotInstr(slotInstr),
      .writerReady(writerReady), .issue(issue), .storeFire(storeFire),
      .storeAddr(storeAddr), .storeData(storeData)
   );

   // Store path out of the core
   PortWriter #(.OUT_ADDR_W(OUT_ADDR_W)) writer_i (
      .clk(clk), .reset(reset), .storeFire(storeFire), .storeAddr(storeAddr),
      .storeData(storeData), .outAck(outAck), .writerReady(writerReady),
      .outReq(outReq), .outAddr(outAddr), .outData(outData)
   );

endmodule

// File: design/PortWriter.sv
`timescale 1ns/1ps

module PortWriter import CorePkg::*; #(
   parameter int OUT_ADDR_W = 16
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  storeFire,
   input  logic [OUT_ADDR_W-1:0] storeAddr,
   input  logic [DATA_W-1:0]     storeData,
   input  logic                  outAck,
   output logic                  writerReady,
   output logic                  outReq,
   output logic [OUT_ADDR_W-1:0] outAddr,
   output logic [DATA_W-1:0]     outData
);

   linkStateT state;

   assign writerReady = (state == LinkIdle);
   // Req only while holding, drops after ack is seen
   assign outReq = (state == LinkHolding);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= LinkIdle;
      end else begin
         case (state)
            LinkIdle: if (storeFire) state <= LinkHolding;
            LinkHolding: if (outAck) state <= LinkWaitRelease;
            // Ready again only once ack is released
            LinkWaitRelease: if (!outAck) state <= LinkIdle;
            default: state <= LinkIdle;
         endcase
      end
   end

   // Address and data stay put for the whole send
   always_ff @(posedge clk) begin
      if (state == LinkIdle && storeFire) begin
         outAddr <= storeAddr;
         outData <= storeData;
      end
   end

endmodule

// File: design/RegFile.sv
`timescale 1ns/1ps

module RegFile import CorePkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [REG_IDX_W-1:0] ra1,
   input  logic [REG_IDX_W-1:0] ra2,
   input  logic                 we,
   input  logic [REG_IDX_W-1:0] wa,
   input  logic [DATA_W-1:0]    wd,
   output logic [DATA_W-1:0]    rd1,
   output logic [DATA_W-1:0]    rd2
);

   logic [DATA_W-1:0] regs [2**REG_IDX_W];

   // Asynchronous read ports
   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

   // r0 is never written, so it stays zero after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 2**REG_IDX_W; i++) regs[i] <= '0;
      end else if (we && wa != '0) begin
         regs[wa] <= wd;
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module CoreTb -o CoreTbSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/CoreTbSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0

// File: src.f
design/CorePkg.sv
design/InstrIntake.sv
design/InstrDecoder.sv
design/RegFile.sv
design/Alu.sv
design/ExecPipe.sv
design/PortWriter.sv
design/MiniMipsCore.sv
bench/CoreTb.sv
